// ==== rtl/memory_game_pkg.sv ====
package memory_game_pkg;

	localparam int n_buttons = 5; // squares, buttons and leds
	localparam int max_len = 8;   // sequence slots

	// starting lengths per level
	localparam int len_easy = 4;
	localparam int len_med = 6;
	localparam int len_hard = 8;

	localparam int wins_per_step = 3; // wins before the sequence grows

	// led on-time in cycles, off-time is the same
	localparam int period_w = 5;
	localparam logic [period_w-1:0] period_slow = 24;
	localparam logic [period_w-1:0] period_mid = 16;
	localparam logic [period_w-1:0] period_fast = 12;

	// round control states
	localparam logic [2:0] st_idle = 3'd0;
	localparam logic [2:0] st_level = 3'd1;
	localparam logic [2:0] st_gen = 3'd2;
	localparam logic [2:0] st_show = 3'd3;
	localparam logic [2:0] st_enter = 3'd4;
	localparam logic [2:0] st_over = 3'd5;

	typedef logic [2:0] symbol_t;
	typedef logic [3:0] seq_len_t;

	// shifted in as one word, read back slot by slot
	typedef union packed {
		logic [3*max_len-1:0] flat;
		symbol_t [max_len-1:0] slot;
	} seq_word_u;

	typedef logic [7:0] bcd_score_t; // tens digit in the upper nibble

	function automatic logic [period_w-1:0] step_period(seq_len_t len);
		if (len <= 4'd5)
			return period_slow;
		else if (len <= 4'd7)
			return period_mid;
		else
			return period_fast;
	endfunction

endpackage

// ==== rtl/show_if.sv ====
`timescale 1ns/100ps

// one round's sequence, from round control to the led presenter
interface show_if;

	logic start; // one-cycle pulse from round control
	memory_game_pkg::seq_word_u seq; // stable from start until done
	memory_game_pkg::seq_len_t length;
	logic done; // pulse after the last off-time

	modport ctrl (
		output start,
		output seq,
		output length,
		input done
	);

	modport presenter (
		input start,
		input seq,
		input length,
		output done
	);

endinterface

// ==== rtl/button_capture.sv ====
`timescale 1ns/100ps

module button_capture (
	input logic clk,
	input logic rst_n,
	input logic [memory_game_pkg::n_buttons-1:0] buttons,
	output logic press_valid,
	output memory_game_pkg::symbol_t press_symbol
);

	logic held; // a press is in progress
	memory_game_pkg::symbol_t first_sym;

	// lowest numbered button wins
	always_comb
	begin
		first_sym = '0;
		for (int i = memory_game_pkg::n_buttons - 1; i >= 0; i--)
			if (buttons[i])
				first_sym = memory_game_pkg::symbol_t'(i);
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			held <= 1'b0;
			press_valid <= 1'b0;
		end
		else
		begin
			press_valid <= 1'b0;
			if (!held && |buttons)
				held <= 1'b1;
			else if (held && !(|buttons))
			begin
				held <= 1'b0;
				press_valid <= 1'b1; // counts on release
			end
		end
	end

	// symbol is taken at the start of the press and kept until release
	always_ff @(posedge clk)
	begin
		if (!held && |buttons)
			press_symbol <= first_sym;
	end

	a_symbol_range: assert property (@(posedge clk) disable iff (!rst_n)
		press_valid |-> press_symbol < memory_game_pkg::n_buttons);

endmodule

// ==== rtl/sequence_source.sv ====
`timescale 1ns/100ps

module sequence_source (
	input logic clk,
	input logic rst_n,
	input logic gen_req,
	output logic gen_done,
	output memory_game_pkg::seq_word_u gen_seq
);

	logic [4:0] lfsr;
	logic [4:0] lfsr_next;
	memory_game_pkg::symbol_t sym;
	memory_game_pkg::seq_len_t cnt; // slots still to fill

	always_comb
	begin
		lfsr_next[4] = lfsr[4] ^ lfsr[1];
		lfsr_next[3] = lfsr[3] ^ lfsr[0];
		lfsr_next[2] = lfsr[2] ^ lfsr_next[4];
		lfsr_next[1] = lfsr[1] ^ lfsr_next[3];
		lfsr_next[0] = lfsr[0] ^ lfsr_next[2];
	end

	// fold 5..7 back onto real squares
	always_comb
	begin
		case (lfsr[2:0])
			3'd5: sym = 3'd0;
			3'd6: sym = 3'd3;
			3'd7: sym = 3'd4;
			default: sym = lfsr[2:0];
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			lfsr <= 5'h1f;
			cnt <= '0;
			gen_done <= 1'b0;
		end
		else
		begin
			lfsr <= lfsr_next; // free running
			gen_done <= 1'b0;
			if (gen_req)
				cnt <= memory_game_pkg::seq_len_t'(memory_game_pkg::max_len);
			else if (cnt != '0)
			begin
				cnt <= cnt - 1'b1;
				gen_done <= (cnt == 4'd1);
			end
		end
	end

	// first symbol drifts down to slot 0 after all eight shifts
	always_ff @(posedge clk)
	begin
		if (!gen_req && cnt != '0)
			gen_seq.flat <= {sym, gen_seq.flat[3*memory_game_pkg::max_len-1:3]};
	end

	// a new request only once the last fill is finished
	a_req_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		gen_req |-> cnt == '0);

endmodule

// ==== rtl/round_control.sv ====
`timescale 1ns/100ps

module round_control (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic level_easy,
	input logic level_med,
	input logic level_hard,
	input logic press_valid,
	input memory_game_pkg::symbol_t press_symbol,
	output logic gen_req,
	input logic gen_done,
	input memory_game_pkg::seq_word_u gen_seq,
	show_if.ctrl show,
	output logic win,
	output logic clear,
	output memory_game_pkg::seq_len_t entry_count,
	output logic game_over
);

	logic [2:0] state;
	memory_game_pkg::seq_len_t length;
	memory_game_pkg::seq_len_t start_len;
	logic [1:0] wins; // wins since the last growth step
	memory_game_pkg::seq_word_u seq_r;
	logic any_level;
	logic match;
	logic last;

	assign any_level = level_easy | level_med | level_hard;

	// easy beats medium beats hard
	always_comb
	begin
		if (level_easy)
			start_len = memory_game_pkg::seq_len_t'(memory_game_pkg::len_easy);
		else if (level_med)
			start_len = memory_game_pkg::seq_len_t'(memory_game_pkg::len_med);
		else
			start_len = memory_game_pkg::seq_len_t'(memory_game_pkg::len_hard);
	end

	assign match = (press_symbol == seq_r.slot[entry_count[2:0]]);
	assign last = (entry_count + 1'b1 == length);

	assign win = (state == memory_game_pkg::st_enter) && press_valid && match && last;
	assign clear = (state == memory_game_pkg::st_level) && start && any_level;
	assign game_over = (state == memory_game_pkg::st_over);

	assign show.seq = seq_r;
	assign show.length = length;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= memory_game_pkg::st_idle;
			gen_req <= 1'b0;
			show.start <= 1'b0;
			length <= '0;
			wins <= '0;
			entry_count <= '0;
		end
		else
		begin
			gen_req <= 1'b0;
			show.start <= 1'b0;
			case (state)
				memory_game_pkg::st_idle:
					if (start)
						state <= memory_game_pkg::st_level;
				memory_game_pkg::st_level:
					if (!start)
						state <= memory_game_pkg::st_idle;
					else if (any_level)
					begin
						length <= start_len;
						wins <= '0;
						entry_count <= '0;
						gen_req <= 1'b1;
						state <= memory_game_pkg::st_gen;
					end
				memory_game_pkg::st_gen:
					if (gen_done)
					begin
						show.start <= 1'b1;
						state <= memory_game_pkg::st_show;
					end
				memory_game_pkg::st_show:
					if (show.done)
					begin
						entry_count <= '0;
						state <= memory_game_pkg::st_enter;
					end
				memory_game_pkg::st_enter:
					if (!start)
						state <= memory_game_pkg::st_idle;
					else if (press_valid && !match)
						state <= memory_game_pkg::st_over; // wrong symbol ends it now
					else if (press_valid)
					begin
						entry_count <= entry_count + 1'b1;
						if (last)
						begin
							gen_req <= 1'b1; // next round right away
							state <= memory_game_pkg::st_gen;
							if (length < memory_game_pkg::max_len)
							begin
								if (wins == 2'(memory_game_pkg::wins_per_step - 1))
								begin
									length <= length + 1'b1;
									wins <= '0;
								end
								else
									wins <= wins + 1'b1;
							end
						end
					end
				memory_game_pkg::st_over:
					if (!start)
						state <= memory_game_pkg::st_idle;
				default:
					state <= memory_game_pkg::st_idle;
			endcase
		end
	end

	// held for the whole show and entry
	always_ff @(posedge clk)
	begin
		if (state == memory_game_pkg::st_gen && gen_done)
			seq_r <= gen_seq;
	end

	// a finished sequence arriving in any other state would be lost
	a_done_in_gen: assert property (@(posedge clk) disable iff (!rst_n)
		gen_done |-> state == memory_game_pkg::st_gen);

endmodule

// ==== rtl/score_keeper.sv ====
`timescale 1ns/100ps

module score_keeper (
	input logic clk,
	input logic rst_n,
	input logic clear,
	input logic win,
	output memory_game_pkg::bcd_score_t score,
	output memory_game_pkg::bcd_score_t high_score
);

	memory_game_pkg::bcd_score_t next_score;

	// bcd increment, ones carry into tens at 9
	always_comb
	begin
		next_score = score;
		if (score[3:0] == 4'd9)
		begin
			next_score[3:0] = 4'd0;
			next_score[7:4] = (score[7:4] == 4'd9) ? 4'd0 : score[7:4] + 4'd1;
		end
		else
			next_score[3:0] = score[3:0] + 4'd1;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			score <= '0;
			high_score <= '0;
		end
		else if (clear)
			score <= '0; // high score survives a new game
		else if (win)
		begin
			score <= next_score;
			if (next_score > high_score) // plain compare works on bcd
				high_score <= next_score;
		end
	end

	a_high_covers_score: assert property (@(posedge clk) disable iff (!rst_n)
		high_score >= score);

endmodule

// ==== rtl/led_presenter.sv ====
`timescale 1ns/100ps

module led_presenter (
	input logic clk,
	input logic rst_n,
	show_if.presenter show,
	output logic [memory_game_pkg::n_buttons-1:0] leds
);

	logic busy;
	logic lit; // on-time of the current step
	logic [2:0] idx; // slot being shown
	logic [memory_game_pkg::period_w-1:0] cnt;
	logic [memory_game_pkg::period_w-1:0] period;
	logic last_step;

	assign period = memory_game_pkg::step_period(show.length);
	assign last_step = ({1'b0, idx} == show.length - 1'b1);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			lit <= 1'b0;
			idx <= '0;
			cnt <= '0;
			show.done <= 1'b0;
		end
		else
		begin
			show.done <= 1'b0;
			if (show.start)
			begin
				busy <= 1'b1;
				lit <= 1'b1;
				idx <= '0;
				cnt <= period - 1'b1;
			end
			else if (busy)
			begin
				if (cnt != '0)
					cnt <= cnt - 1'b1;
				else if (lit)
				begin
					lit <= 1'b0; // go dark for the same time
					cnt <= period - 1'b1;
				end
				else if (last_step)
				begin
					busy <= 1'b0;
					show.done <= 1'b1;
				end
				else
				begin
					idx <= idx + 1'b1;
					lit <= 1'b1;
					cnt <= period - 1'b1;
				end
			end
		end
	end

	// symbol k lights led k
	always_comb
	begin
		for (int i = 0; i < memory_game_pkg::n_buttons; i++)
			leds[i] = lit && (show.seq.slot[idx] == memory_game_pkg::symbol_t'(i));
	end

	// a new round only after the last one is done
	a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		show.start |-> !busy);

endmodule

// ==== rtl/memory_game.sv ====
`timescale 1ns/100ps

module memory_game (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic level_easy,
	input logic level_med,
	input logic level_hard,
	input logic [memory_game_pkg::n_buttons-1:0] buttons,
	output logic [memory_game_pkg::n_buttons-1:0] leds,
	output memory_game_pkg::bcd_score_t score,
	output memory_game_pkg::bcd_score_t high_score,
	output memory_game_pkg::seq_len_t entry_count,
	output logic game_over
);

	logic press_valid;
	memory_game_pkg::symbol_t press_symbol;
	logic gen_req;
	logic gen_done;
	memory_game_pkg::seq_word_u gen_seq;
	logic win;
	logic clear;

	show_if u_show ();

	button_capture u_buttons (
		.clk(clk),
		.rst_n(rst_n),
		.buttons(buttons),
		.press_valid(press_valid),
		.press_symbol(press_symbol)
	);

	sequence_source u_source (
		.clk(clk),
		.rst_n(rst_n),
		.gen_req(gen_req),
		.gen_done(gen_done),
		.gen_seq(gen_seq)
	);

	round_control u_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.level_easy(level_easy),
		.level_med(level_med),
		.level_hard(level_hard),
		.press_valid(press_valid),
		.press_symbol(press_symbol),
		.gen_req(gen_req),
		.gen_done(gen_done),
		.gen_seq(gen_seq),
		.show(u_show),
		.win(win),
		.clear(clear),
		.entry_count(entry_count),
		.game_over(game_over)
	);

	score_keeper u_score (
		.clk(clk),
		.rst_n(rst_n),
		.clear(clear),
		.win(win),
		.score(score),
		.high_score(high_score)
	);

	led_presenter u_leds (
		.clk(clk),
		.rst_n(rst_n),
		.show(u_show),
		.leds(leds)
	);

endmodule

// ==== testbench/tb_memory_game.sv ====
`timescale 1ns/100ps

module tb_memory_game;

	logic clk;
	logic rst_n;
	logic start;
	logic level_easy;
	logic level_med;
	logic level_hard;
	logic [4:0] buttons;
	logic [4:0] leds;
	memory_game_pkg::bcd_score_t score;
	memory_game_pkg::bcd_score_t high_score;
	memory_game_pkg::seq_len_t entry_count;
	logic game_over;

	logic [31:0] rng;
	int errors; // written by the compare process only
	int checks;
	int tests;
	int best_wins; // best score over all games so far
	logic timed_out;
	string timeout_what;

	// expectations handed over to the compare process
	int cmp_req;
	int cmp_done;
	memory_game_pkg::bcd_score_t exp_score;
	memory_game_pkg::bcd_score_t exp_high;
	logic exp_over;
	memory_game_pkg::seq_len_t exp_len;
	memory_game_pkg::seq_len_t exp_entry;
	logic chk_steps;
	int got_steps;
	memory_game_pkg::symbol_t shown[$];

	memory_game u_dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] step_lfsr(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			rng = step_lfsr(rng); // one step per bit
			v = (v << 1) | int'(rng[0]);
		end
		return v;
	endfunction

	function automatic memory_game_pkg::seq_len_t expected_length(input logic easy,
		input logic med, input logic hard, input int wins);
		int len;
		if (easy)
			len = 4;
		else if (med)
			len = 6;
		else if (hard)
			len = 8;
		else
			len = 0;
		len = len + wins / 3; // one longer per three wins
		if (len > 8)
			len = 8;
		return memory_game_pkg::seq_len_t'(len);
	endfunction

	function automatic memory_game_pkg::bcd_score_t expected_bcd(input int wins);
		int tens;
		int ones;
		tens = (wins / 10) % 10;
		ones = wins % 10;
		return {4'(tens), 4'(ones)};
	endfunction

	task automatic check_score(input memory_game_pkg::bcd_score_t got,
		input memory_game_pkg::bcd_score_t exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_length(input memory_game_pkg::seq_len_t got,
		input memory_game_pkg::seq_len_t exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_symbol(input memory_game_pkg::symbol_t sym, input string what);
		checks++;
		if (sym > 3'd4)
		begin
			errors++;
			$display("ERR %0t: %s %0d is no square", $time, what, sym);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// compare process, runs on a request from the stimulus
	always @(negedge clk)
	begin
		if (cmp_req != cmp_done)
		begin
			check_score(score, exp_score, "score");
			check_score(high_score, exp_high, "high score");
			check_flag(game_over, exp_over, "game_over");
			check_flag(|leds, 1'b0, "leds between shows");
			check_length(entry_count, exp_entry, "entry_count");
			if (chk_steps)
			begin
				check_length(memory_game_pkg::seq_len_t'(got_steps), exp_len, "steps shown");
				foreach (shown[i])
					check_symbol(shown[i], "shown symbol");
			end
			cmp_done = cmp_req;
		end
	end

	always @(posedge clk)
	begin
		if (timed_out)
		begin
			$display("run stopped by a timeout: %s", timeout_what);
			$display("=== FAIL ===");
			$finish;
		end
	end

	task automatic note_timeout(input string what);
		timeout_what = what;
		timed_out = 1'b1;
	endtask

	task automatic request_compare();
		int t;
		@(posedge clk);
		#2;
		cmp_req++;
		t = 0;
		while (cmp_done != cmp_req && t < 4)
		begin
			@(posedge clk);
			t++;
		end
		if (cmp_done != cmp_req)
			note_timeout("compare process did not answer");
	endtask

	// waits until score and game_over reach the given values, or gives up
	task automatic wait_settle(input memory_game_pkg::bcd_score_t target, input logic over);
		int t;
		t = 0;
		@(negedge clk);
		while ((score !== target || game_over !== over) && t < 10)
		begin
			@(negedge clk);
			t++;
		end
	endtask

	// player model, records one symbol per led pulse
	task automatic watch_show(output int steps);
		int t;
		int on;
		int dark;
		logic was_lit;
		memory_game_pkg::symbol_t sym;
		steps = 0;
		on = 0;
		dark = 0;
		t = 0;
		was_lit = 1'b0;
		shown.delete();
		while (!(steps > 0 && dark > 3 * on) && t < 5000) // long dark gap ends the show
		begin
			@(negedge clk);
			t++;
			if (leds != '0)
			begin
				if (!was_lit)
				begin
					sym = 3'd7; // no single led lit, so no square
					if ($countones(leds) == 1)
						for (int i = 4; i >= 0; i--)
							if (leds[i])
								sym = memory_game_pkg::symbol_t'(i);
					shown.push_back(sym);
					steps++;
					on = 0;
				end
				on++;
				dark = 0;
				was_lit = 1'b1;
			end
			else
			begin
				dark++;
				was_lit = 1'b0;
			end
		end
		if (!(steps > 0 && dark > 3 * on))
			note_timeout("no complete show on the LEDs");
	endtask

	task automatic press(input memory_game_pkg::symbol_t sym);
		int hold;
		hold = 1 + rand_bits(2);
		@(posedge clk);
		#2;
		buttons = '0;
		buttons[sym] = 1'b1;
		repeat (hold) @(posedge clk);
		#2;
		buttons = '0;
		repeat (2) @(posedge clk); // event goes out after release
	endtask

	task automatic check_reset_state();
		int e0;
		e0 = errors;
		tests++;
		exp_score = 8'h00;
		exp_high = 8'h00;
		exp_over = 1'b0;
		exp_entry = '0;
		chk_steps = 1'b0;
		request_compare();
		$display("test %0d reset state: %s", tests, (errors == e0) ? "ok" : "failed");
	endtask

	task automatic run_game(input string name, input logic easy, input logic med,
		input logic hard, input int rounds);
		int steps;
		int p;
		int e0;
		memory_game_pkg::symbol_t wrong;
		e0 = errors;
		tests++;
		@(posedge clk);
		#2;
		level_easy = easy;
		level_med = med;
		level_hard = hard;
		start = 1'b1;
		exp_score = expected_bcd(0); // new game clears the score only
		exp_high = expected_bcd(best_wins);
		exp_over = 1'b0;
		exp_entry = '0;
		chk_steps = 1'b0;
		wait_settle(exp_score, 1'b0);
		request_compare();
		for (int r = 0; r < rounds; r++)
		begin
			watch_show(steps);
			got_steps = steps;
			exp_len = expected_length(easy, med, hard, r);
			foreach (shown[i])
				press(shown[i]);
			if (r + 1 > best_wins)
				best_wins = r + 1;
			exp_score = expected_bcd(r + 1);
			exp_high = expected_bcd(best_wins);
			exp_entry = exp_len;
			chk_steps = 1'b1;
			wait_settle(exp_score, 1'b0);
			request_compare();
		end
		// last round, a wrong symbol at a random step
		watch_show(steps);
		got_steps = steps;
		exp_len = expected_length(easy, med, hard, rounds);
		chk_steps = 1'b1;
		if (steps > 0)
		begin
			p = rand_bits(3) % steps;
			for (int i = 0; i < p; i++)
				press(shown[i]);
			wrong = memory_game_pkg::symbol_t'((int'(shown[p]) + 1 + rand_bits(2)) % 5);
			press(wrong);
			exp_over = 1'b1;
			exp_entry = memory_game_pkg::seq_len_t'(p);
			wait_settle(exp_score, 1'b1);
			request_compare();
			press(memory_game_pkg::symbol_t'(rand_bits(3) % 5)); // ignored after game over
			press(memory_game_pkg::symbol_t'(rand_bits(3) % 5));
			chk_steps = 1'b0;
			request_compare();
		end
		@(posedge clk);
		#2;
		start = 1'b0;
		level_easy = 1'b0;
		level_med = 1'b0;
		level_hard = 1'b0;
		$display("test %0d %s: %s", tests, name, (errors == e0) ? "ok" : "failed");
	endtask

	initial
	begin
		rng = 32'h6892;
		errors = 0;
		checks = 0;
		tests = 0;
		best_wins = 0;
		timed_out = 1'b0;
		cmp_req = 0;
		cmp_done = 0;
		chk_steps = 1'b0;
		got_steps = 0;
		rst_n = 1'b0;
		start = 1'b0;
		level_easy = 1'b0;
		level_med = 1'b0;
		level_hard = 1'b0;
		buttons = '0;
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
		check_reset_state();
		run_game("easy over medium, bcd carry", 1'b1, 1'b1, 1'b0, 11);
		run_game("medium over hard, length cap", 1'b0, 1'b1, 1'b1, 9);
		run_game("hard only", 1'b0, 1'b0, 1'b1, 2);
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0 && !timed_out)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== compile.f ====
rtl/memory_game_pkg.sv
rtl/show_if.sv
rtl/button_capture.sv
rtl/sequence_source.sv
rtl/round_control.sv
rtl/score_keeper.sv
rtl/led_presenter.sv
rtl/memory_game.sv
testbench/tb_memory_game.sv

// ==== Makefile ====
# Verilator simulation of the memory game

.PHONY: all build lint clean

all: build
	./obj_dir/Vtb_memory_game | tee sim.log
	grep -q "=== PASS ===" sim.log

build:
	verilator --binary --timing --assert -f compile.f --top-module tb_memory_game

lint:
	verilator --lint-only --timing -f compile.f --top-module tb_memory_game

clean:
	rm -rf obj_dir sim.log
